/* all.f */
+incdir+.
convPkg.sv
windowScan.sv
pixelFetch.sv
boothMult.sv
kernelMac.sv
biasRelu.sv
convCore.sv
convTb.sv

/* Bender.yml */
package:
  name: conv_core

export_include_dirs:
  - .

sources:
  - files:
      - convPkg.sv
      - windowScan.sv
      - pixelFetch.sv
      - boothMult.sv
      - kernelMac.sv
      - biasRelu.sv
      - convCore.sv
  - target: test
    files:
      - convTb.sv

/* convTb.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module convTb import convPkg::*; ();

    localparam int SIDE           = 1 << `CONV_COORD_W;
    localparam int WINDOWS        = SIDE * SIDE;
    localparam int TIMEOUT_CYCLES = 1000000;    // 4096 windows x 9 taps x 13 cycles, doubled

    logic   clk;
    logic   reset;
    logic   memRead;
    addr_t  memAddr;
    pixel_t memData;
    logic   resValid;
    logic   resReady;
    pixel_t resK0;
    pixel_t resK1;
    addr_t  resCentre;
    logic   resLast;

    pixel_t image [0:WINDOWS-1];
    pixel_t gotK0 [0:WINDOWS-1];    // results by centre address
    pixel_t gotK1 [0:WINDOWS-1];
    pixel_t coefK0 [0:8];
    pixel_t coefK1 [0:8];
    int     expReads [$];           // read addresses in the order they must appear

    integer seed = 64342;
    int     errorCount;
    int     cycleCount;
    int     resultCount;
    int     holdCount;
    int     burstLeft;
    int     nextAddr;
    logic   backPressure;
    logic   heldValid;
    pixel_t heldK0;
    pixel_t heldK1;
    addr_t  heldCentre;
    logic   heldLast;

    convCore dut_i (
        .clk(clk), .reset(reset),
        .memRead(memRead), .memAddr(memAddr), .memData(memData),
        .resValid(resValid), .resReady(resReady), .resK0(resK0), .resK1(resK1),
        .resCentre(resCentre), .resLast(resLast)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abortRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    // rounded and biased sum before ReLU, straight from the image
    function automatic pixel_t biasedValue(input int centre, input int kernel);
        int          row;
        int          col;
        int          tapRow;
        int          tapCol;
        longint      acc;
        logic [63:0] accBits;
        pixel_t      rounded;
        pixel_t      bias;
        row = centre / SIDE;
        col = centre % SIDE;
        acc = 0;
        for (int t = 0; t < 9; t++) begin
            tapRow = row + t / 3 - 1;
            tapCol = col + t % 3 - 1;
            if (tapRow >= 0 && tapRow < SIDE && tapCol >= 0 && tapCol < SIDE)
                acc += longint'(image[tapRow * SIDE + tapCol])
                       * longint'(kernel ? coefK1[t] : coefK0[t]);
        end
        accBits = acc;
        rounded = accBits[35:16] + accBits[15];     // wraps at 20 bits
        bias    = kernel ? `CONV_BIAS1 : `CONV_BIAS0;
        return rounded + bias;
    endfunction

    function automatic pixel_t expectedResult(input int centre, input int kernel);
        pixel_t biased;
        biased = biasedValue(centre, kernel);
        return biased[`CONV_DATA_W-1] ? '0 : biased;
    endfunction

    task automatic checkWindow(input int centre);
        checkValue($sformatf("resK0 at centre %0d", centre), gotK0[centre],
                   expectedResult(centre, 0));
        checkValue($sformatf("resK1 at centre %0d", centre), gotK1[centre],
                   expectedResult(centre, 1));
    endtask

    // every in-range tap of every window, raster order
    task automatic buildReadList;
        int tapRow;
        int tapCol;
        expReads.delete();
        for (int c = 0; c < WINDOWS; c++) begin
            for (int t = 0; t < 9; t++) begin
                tapRow = c / SIDE + t / 3 - 1;
                tapCol = c % SIDE + t % 3 - 1;
                if (tapRow >= 0 && tapRow < SIDE && tapCol >= 0 && tapCol < SIDE)
                    expReads.push_back(tapRow * SIDE + tapCol);
            end
        end
    endtask

    task automatic fillRandom;
        for (int a = 0; a < WINDOWS; a++)
            image[a] = pixel_t'($random(seed));
    endtask

    // top half near +1.0, bottom half near -1.0, small address-dependent offset
    task automatic fillSplit;
        pixel_t mag;
        for (int a = 0; a < WINDOWS; a++) begin
            mag      = 20'h10000 + ((a * 5) & 20'h01FFF);
            image[a] = (a < WINDOWS / 2) ? mag : -mag;
        end
    endtask

    task automatic resetDut;
        reset <= 1'b0;
        @(posedge clk);     // DUT takes reset on this edge
        resultCount = 0;
        holdCount   = 0;
        heldValid   = 1'b0;
        cycleCount  = 0;
        buildReadList();
        repeat (9) begin
            @(posedge clk);
            checkValue("resValid", resValid, 1'b0);
            checkValue("memRead", memRead, 1'b0);
        end
        reset <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            checkValue("resValid", resValid, 1'b0);
            checkValue("memRead", memRead, 1'b0);
        end
    endtask

    // wait for the whole frame, then make sure nothing more comes out
    task automatic runFrame;
        while (resultCount < WINDOWS)
            @(posedge clk);
        repeat (300) @(posedge clk);
        checkValue("reads left in frame", expReads.size(), 0);
    endtask

    task automatic testResetState;
        fillRandom();
        resetDut();
    endtask

    task automatic testCornerPadding;
        fillRandom();
        backPressure = 1'b0;
        resetDut();
        runFrame();
        for (int c = 0; c < SIDE; c++)
            checkWindow(c);             // first row, both upper corners
        checkWindow((SIDE - 1) * SIDE);
        checkWindow(WINDOWS - 1);
    endtask

    task automatic testReluClamp;
        fillSplit();
        backPressure = 1'b0;
        resetDut();
        runFrame();
        for (int c = 0; c < WINDOWS; c++)
            checkWindow(c);
    endtask

    task automatic testBackPressure;
        fillRandom();
        backPressure = 1'b1;
        resetDut();
        runFrame();
        backPressure = 1'b0;
        for (int c = 0; c < WINDOWS; c++)
            checkWindow(c);
        checkValue("stalled result cycles seen", holdCount > 0, 1'b1);
    endtask

    // image memory, one cycle read latency, junk when idle
    always @(posedge clk) begin
        if (memRead === 1'b1)
            memData <= image[memAddr];
        else
            memData <= ~image[memAddr];
    end

    // output ready, short random drops plus occasional long bursts
    always @(posedge clk) begin
        if (!backPressure) begin
            resReady <= 1'b1;
        end else if (burstLeft > 0) begin
            burstLeft = burstLeft - 1;
            resReady <= 1'b0;
        end else if (($random(seed) & 511) == 0) begin
            burstLeft = $random(seed) & 255;
            resReady <= 1'b0;
        end else begin
            resReady <= ($random(seed) & 3) != 0;
        end
    end

    // read monitor, padded taps must never show up here
    always @(posedge clk) begin
        if (reset === 1'b1 && memRead === 1'b1) begin
            if (expReads.size() == 0) begin
                abortRun("memory read issued after the last tap of the frame");
            end else begin
                nextAddr = expReads.pop_front();
                checkValue("memAddr", memAddr, nextAddr);
            end
        end
    end

    // result monitor
    always @(posedge clk) begin
        if (reset !== 1'b1) begin
            heldValid = 1'b0;
        end else begin
            if (heldValid) begin
                checkValue("resValid", resValid, 1'b1);
                checkValue("resK0", resK0, heldK0);
                checkValue("resK1", resK1, heldK1);
                checkValue("resCentre", resCentre, heldCentre);
                checkValue("resLast", resLast, heldLast);
            end
            if (resValid === 1'b1) begin
                if (resultCount >= WINDOWS) begin
                    abortRun("result arrived after the last window of the frame");
                end else if (resReady) begin
                    checkValue("resCentre", resCentre, resultCount);
                    checkValue("resLast", resLast, resultCount == WINDOWS - 1);
                    gotK0[resultCount] = resK0;
                    gotK1[resultCount] = resK1;
                    resultCount++;
                    heldValid = 1'b0;
                end else begin
                    heldK0     = resK0;     // must not move until taken
                    heldK1     = resK1;
                    heldCentre = resCentre;
                    heldLast   = resLast;
                    heldValid  = 1'b1;
                    holdCount++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES)
            abortRun($sformatf("timeout: frame not finished after %0d cycles", cycleCount));
    end

    initial begin
        reset        = 1'b0;
        resReady     = 1'b0;
        memData      = '0;
        backPressure = 1'b0;
        burstLeft    = 0;
        errorCount   = 0;
        cycleCount   = 0;
        resultCount  = 0;
        holdCount    = 0;
        heldValid    = 1'b0;
        coefK0 = '{`CONV_K0_0, `CONV_K0_1, `CONV_K0_2, `CONV_K0_3, `CONV_K0_4,
                   `CONV_K0_5, `CONV_K0_6, `CONV_K0_7, `CONV_K0_8};
        coefK1 = '{`CONV_K1_0, `CONV_K1_1, `CONV_K1_2, `CONV_K1_3, `CONV_K1_4,
                   `CONV_K1_5, `CONV_K1_6, `CONV_K1_7, `CONV_K1_8};

        testResetState();
        testCornerPadding();
        testReluClamp();
        testBackPressure();

        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* convCore.sv */
`timescale 1ns/1ps

module convCore import convPkg::*; (
    input  logic   clk,
    input  logic   reset,
    output logic   memRead,
    output addr_t  memAddr,
    input  pixel_t memData,
    output logic   resValid,
    input  logic   resReady,
    output pixel_t resK0,
    output pixel_t resK1,
    output addr_t  resCentre,
    output logic   resLast
);

    // scan to fetch
    logic   tapValid;
    logic   tapReady;
    addr_t  tapAddr;
    logic   tapPad;
    tap_t   tapIdx;
    addr_t  tapCentre;
    logic   tapLast;

    // fetch to mac
    logic   pixValid;
    logic   pixReady;
    pixel_t pixData;
    tap_t   pixIdx;
    addr_t  pixCentre;
    logic   pixLast;

    // mac to output stage
    logic   sumValid;
    logic   sumReady;
    acc_t   sum0;
    acc_t   sum1;
    addr_t  sumCentre;
    logic   sumLast;

    windowScan scan (
        .clk(clk), .reset(reset),
        .tapValid(tapValid), .tapReady(tapReady), .tapAddr(tapAddr), .tapPad(tapPad),
        .tapIdx(tapIdx), .tapCentre(tapCentre), .tapLast(tapLast)
    );

    pixelFetch fetch (
        .clk(clk), .reset(reset),
        .tapValid(tapValid), .tapReady(tapReady), .tapAddr(tapAddr), .tapPad(tapPad),
        .tapIdx(tapIdx), .tapCentre(tapCentre), .tapLast(tapLast),
        .memRead(memRead), .memAddr(memAddr), .memData(memData),
        .pixValid(pixValid), .pixReady(pixReady), .pixData(pixData),
        .pixIdx(pixIdx), .pixCentre(pixCentre), .pixLast(pixLast)
    );

    kernelMac mac (
        .clk(clk), .reset(reset),
        .pixValid(pixValid), .pixReady(pixReady), .pixData(pixData),
        .pixIdx(pixIdx), .pixCentre(pixCentre), .pixLast(pixLast),
        .sumValid(sumValid), .sumReady(sumReady), .sum0(sum0), .sum1(sum1),
        .sumCentre(sumCentre), .sumLast(sumLast)
    );

    biasRelu post (
        .clk(clk), .reset(reset),
        .sumValid(sumValid), .sumReady(sumReady), .sum0(sum0), .sum1(sum1),
        .sumCentre(sumCentre), .sumLast(sumLast),
        .resValid(resValid), .resReady(resReady), .resK0(resK0), .resK1(resK1),
        .resCentre(resCentre), .resLast(resLast)
    );

endmodule

/* biasRelu.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module biasRelu import convPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   sumValid,
    output logic   sumReady,
    input  acc_t   sum0,
    input  acc_t   sum1,
    input  addr_t  sumCentre,
    input  logic   sumLast,
    output logic   resValid,
    input  logic   resReady,
    output pixel_t resK0,
    output pixel_t resK1,
    output addr_t  resCentre,
    output logic   resLast
);

    logic take;

    // round to Q4.16, add bias, clamp negatives to zero
    function automatic pixel_t roundBiasRelu(input acc_t accIn, input pixel_t bias);
        pixel_t rounded;
        pixel_t biased;
        rounded = accIn[`CONV_FRAC_W +: `CONV_DATA_W] + pixel_t'(accIn[`CONV_FRAC_W-1]);
        biased  = rounded + bias;
        return biased[`CONV_DATA_W-1] ? '0 : biased;
    endfunction

    assign sumReady = !resValid || resReady;
    assign take     = sumValid && sumReady;

    always_ff @(posedge clk) begin
        if (!reset)
            resValid <= 1'b0;
        else if (take)
            resValid <= 1'b1;
        else if (resReady)
            resValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resK0     <= roundBiasRelu(sum0, `CONV_BIAS0);
            resK1     <= roundBiasRelu(sum1, `CONV_BIAS1);
            resCentre <= sumCentre;
            resLast   <= sumLast;
        end
    end

endmodule

/* kernelMac.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module kernelMac import convPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   pixValid,
    output logic   pixReady,
    input  pixel_t pixData,
    input  tap_t   pixIdx,
    input  addr_t  pixCentre,
    input  logic   pixLast,
    output logic   sumValid,
    input  logic   sumReady,
    output acc_t   sum0,
    output acc_t   sum1,
    output addr_t  sumCentre,
    output logic   sumLast
);

    pixel_t coef0;
    pixel_t coef1;
    logic   accept;
    logic   busy0;
    logic   busy1;
    logic   done0;
    logic   done1;
    acc_t   product0;
    acc_t   product1;
    logic   lastTap;    // product in flight closes the window

    always_comb begin
        case (pixIdx)
            0: coef0 = `CONV_K0_0;
            1: coef0 = `CONV_K0_1;
            2: coef0 = `CONV_K0_2;
            3: coef0 = `CONV_K0_3;
            4: coef0 = `CONV_K0_4;
            5: coef0 = `CONV_K0_5;
            6: coef0 = `CONV_K0_6;
            7: coef0 = `CONV_K0_7;
            default: coef0 = `CONV_K0_8;
        endcase
        case (pixIdx)
            0: coef1 = `CONV_K1_0;
            1: coef1 = `CONV_K1_1;
            2: coef1 = `CONV_K1_2;
            3: coef1 = `CONV_K1_3;
            4: coef1 = `CONV_K1_4;
            5: coef1 = `CONV_K1_5;
            6: coef1 = `CONV_K1_6;
            7: coef1 = `CONV_K1_7;
            default: coef1 = `CONV_K1_8;
        endcase
    end

    // a finished window blocks the next one until it is taken
    assign pixReady = !busy0 && !busy1 && (!sumValid || sumReady);
    assign accept   = pixValid && pixReady;

    boothMult mult0 (
        .clk(clk),
        .reset(reset),
        .start(accept),
        .multiplicand(pixData),
        .multiplier(coef0),
        .busy(busy0),
        .done(done0),
        .product(product0)
    );

    boothMult mult1 (
        .clk(clk),
        .reset(reset),
        .start(accept),
        .multiplicand(pixData),
        .multiplier(coef1),
        .busy(busy1),
        .done(done1),
        .product(product1)
    );

    always_ff @(posedge clk) begin
        if (!reset) begin
            sumValid <= 1'b0;
            lastTap  <= 1'b0;
        end else begin
            if (accept)
                lastTap <= pixLast;
            if (sumValid && sumReady)
                sumValid <= 1'b0;
            if (done0 && lastTap)
                sumValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && pixIdx == '0) begin
            sum0 <= '0;     // new window
            sum1 <= '0;
        end
        if (done0)
            sum0 <= sum0 + product0;
        if (done1)
            sum1 <= sum1 + product1;
        if (accept) begin
            sumCentre <= pixCentre;
            sumLast   <= &pixCentre;   // centre (63,63) ends the frame
        end
    end

endmodule

/* boothMult.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module boothMult import convPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  pixel_t multiplicand,
    input  pixel_t multiplier,
    output logic   busy,
    output logic   done,
    output acc_t   product
);

    localparam int STEP_W = $clog2(`CONV_BOOTH_STEPS);

    boothState_t           state;
    logic [STEP_W-1:0]     step;
    acc_t                  mcand;       // shifted left two bits per step
    logic [`CONV_DATA_W:0] recode;      // remaining multiplier bits
    acc_t                  mcandIn;
    logic [`CONV_DATA_W:0] recodeIn;

    // one recoded digit in -2..+2 times m
    function automatic acc_t partial(input logic [2:0] bits, input acc_t m);
        case (bits)
            3'b001, 3'b010: partial = m;
            3'b011:         partial = m <<< 1;
            3'b100:         partial = -(m <<< 1);
            3'b101, 3'b110: partial = -m;
            default:        partial = '0;
        endcase
    endfunction

    assign mcandIn  = acc_t'(multiplicand);   // sign extended
    assign recodeIn = {multiplier, 1'b0};     // implicit bit below lsb

    assign busy = (state != idle);
    assign done = (state == convPkg::done);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= idle;
            step  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        step  <= STEP_W'(1);   // step 0 taken at start
                    end
                end
                run: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(`CONV_BOOTH_STEPS - 1))
                        state <= convPkg::done;
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath, first partial product straight from the inputs
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            product <= partial(recodeIn[2:0], mcandIn);
            mcand   <= mcandIn <<< 2;
            recode  <= recodeIn >> 2;
        end else if (state == run) begin
            product <= product + partial(recode[2:0], mcand);
            mcand   <= mcand <<< 2;
            recode  <= recode >> 2;
        end
    end

endmodule

/* pixelFetch.sv */
`timescale 1ns/1ps

module pixelFetch import convPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   tapValid,
    output logic   tapReady,
    input  addr_t  tapAddr,
    input  logic   tapPad,
    input  tap_t   tapIdx,
    input  addr_t  tapCentre,
    input  logic   tapLast,
    output logic   memRead,
    output addr_t  memAddr,
    input  pixel_t memData,
    output logic   pixValid,
    input  logic   pixReady,
    output pixel_t pixData,
    output tap_t   pixIdx,
    output addr_t  pixCentre,
    output logic   pixLast
);

    logic   accept;
    logic   fresh;      // memData belongs to the held tap this cycle
    logic   padHeld;
    pixel_t freshData;
    pixel_t dataHeld;

    assign tapReady = !pixValid || pixReady;
    assign accept   = tapValid && tapReady;
    assign memRead  = accept && !tapPad;   // padded taps never touch memory
    assign memAddr  = tapAddr;

    assign freshData = padHeld ? '0 : memData;
    assign pixData   = fresh ? freshData : dataHeld;

    always_ff @(posedge clk) begin
        if (!reset) begin
            pixValid <= 1'b0;
            fresh    <= 1'b0;
        end else begin
            fresh <= accept;
            if (accept)
                pixValid <= 1'b1;
            else if (pixReady)
                pixValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fresh)
            dataHeld <= freshData;  // keep it in case of a stall
        if (accept) begin
            padHeld   <= tapPad;
            pixIdx    <= tapIdx;
            pixCentre <= tapCentre;
            pixLast   <= tapLast;
        end
    end

endmodule

/* windowScan.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module windowScan import convPkg::*; (
    input  logic  clk,
    input  logic  reset,
    output logic  tapValid,
    input  logic  tapReady,
    output addr_t tapAddr,
    output logic  tapPad,
    output tap_t  tapIdx,
    output addr_t tapCentre,
    output logic  tapLast
);

    localparam int EXT_W = `CONV_COORD_W + 1;   // one spare bit catches -1 and 64

    coord_t           centreRow;
    coord_t           centreCol;
    logic             frameDone;
    logic             advance;
    logic             frameEnd;
    logic [1:0]       rowOff;
    logic [1:0]       colOff;
    logic [EXT_W-1:0] tapRow;
    logic [EXT_W-1:0] tapCol;

    // offsets as 2-bit two's complement, -1 / 0 / +1
    always_comb begin
        if (tapIdx < 3)
            rowOff = 2'b11;
        else if (tapIdx < 6)
            rowOff = 2'b00;
        else
            rowOff = 2'b01;
        case (tapIdx)
            0, 3, 6: colOff = 2'b11;
            1, 4, 7: colOff = 2'b00;
            default: colOff = 2'b01;
        endcase
    end

    assign tapRow = {1'b0, centreRow} + {{(EXT_W-2){rowOff[1]}}, rowOff};
    assign tapCol = {1'b0, centreCol} + {{(EXT_W-2){colOff[1]}}, colOff};

    assign tapPad    = tapRow[EXT_W-1] | tapCol[EXT_W-1];   // outside the image
    assign tapAddr   = {tapRow[EXT_W-2:0], tapCol[EXT_W-2:0]};
    assign tapCentre = {centreRow, centreCol};
    assign tapLast   = (tapIdx == tap_t'(`CONV_TAPS - 1));

    assign advance  = tapValid && tapReady;
    assign frameEnd = tapLast && (&centreRow) && (&centreCol);

    always_ff @(posedge clk) begin
        if (!reset) begin
            tapValid  <= 1'b0;
            frameDone <= 1'b0;
            centreRow <= '0;
            centreCol <= '0;
            tapIdx    <= '0;
        end else if (!tapValid) begin
            if (!frameDone)
                tapValid <= 1'b1;   // first edge out of reset
        end else if (advance) begin
            if (tapLast) begin
                tapIdx <= '0;
                if (&centreCol) begin
                    centreCol <= '0;
                    centreRow <= centreRow + 1'b1;
                end else begin
                    centreCol <= centreCol + 1'b1;
                end
                if (frameEnd) begin
                    tapValid  <= 1'b0;
                    frameDone <= 1'b1;  // idle until next reset
                end
            end else begin
                tapIdx <= tapIdx + 1'b1;
            end
        end
    end

endmodule

/* convPkg.sv */
`include "conv_config.svh"

package convPkg;

    typedef logic signed [`CONV_DATA_W-1:0] pixel_t;    // Q4.16
    typedef logic signed [`CONV_ACC_W-1:0]  acc_t;      // product or window sum
    typedef logic [`CONV_ADDR_W-1:0]        addr_t;     // row, then column
    typedef logic [`CONV_COORD_W-1:0]       coord_t;
    typedef logic [$clog2(`CONV_TAPS)-1:0]  tap_t;      // 0..8 inside the window

    // sequential multiplier states
    typedef enum logic [1:0] {
        idle,
        run,
        done
    } boothState_t;

endpackage

/* conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// data path widths, Q4.16 pixels and coefficients
`define CONV_DATA_W      20
`define CONV_FRAC_W      16
`define CONV_ACC_W       40    // full product sum

// image geometry, side is 2**CONV_COORD_W
`define CONV_COORD_W     6
`define CONV_ADDR_W      (2 * `CONV_COORD_W)
`define CONV_TAPS        9

// radix-4 Booth, two multiplier bits per step
`define CONV_BOOTH_STEPS 10

// kernel 0, row-major from the upper left tap
`define CONV_K0_0        20'h0A89E
`define CONV_K0_1        20'h092D5
`define CONV_K0_2        20'h06D43
`define CONV_K0_3        20'h01004
`define CONV_K0_4        20'hF8F71
`define CONV_K0_5        20'hF6E54
`define CONV_K0_6        20'hFA6D7
`define CONV_K0_7        20'hFC834
`define CONV_K0_8        20'hFAC19

// kernel 1, same tap order
`define CONV_K1_0        20'hFDB55
`define CONV_K1_1        20'h02992
`define CONV_K1_2        20'hFC994
`define CONV_K1_3        20'h050FD
`define CONV_K1_4        20'h02F20
`define CONV_K1_5        20'h0202D
`define CONV_K1_6        20'h03BD7
`define CONV_K1_7        20'hFD369
`define CONV_K1_8        20'h05E68

`define CONV_BIAS0       20'h01310
`define CONV_BIAS1       20'hF7295

`endif
